//--- filelist.f
src/synth_types_pkg.sv
src/synth_regmap_pkg.sv
src/fm_reg_bank.sv
src/operator_router.sv
src/fm_operator.sv
src/sample_mixer.sv
src/fm_channels.sv
verif/tb_clock_gen.sv
verif/fm_channels_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the testbench with Verilator, exits non-zero unless the log shows a pass
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module fm_channels_tb \
    -f filelist.f \
    --Mdir obj_dir -o sim_fm_channels

./obj_dir/sim_fm_channels | tee sim.log

grep -q ">>> PASS" sim.log
echo "simulation passed"

//--- src/fm_channels.sv
// four two-op channels mixed to mono, with out_valid two cycles after an accepted sample_clk_en
`timescale 1ns/1ps

module fm_channels (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            sample_clk_en,
    input  synth_regmap_pkg::reg_write_t                    cfg,
    input  logic                                            cfg_valid,
    output logic                                            cfg_ready,
    output logic signed [synth_types_pkg::SAMPLE_WIDTH-1:0] sample,
    output logic                                            out_valid,
    input  logic                                            out_ready
);
    import synth_types_pkg::*;

    ch_cfg_t                        ch_cfg [N_CHANNELS];
    op_cfg_t                        op_cfg [N_OPERATORS];
    op_ctrl_t                       op_ctrl [N_OPERATORS];
    logic [WAVE_INDEX_WIDTH-1:0]    op_mod [N_OPERATORS];
    logic signed [OP_OUT_WIDTH-1:0] op_out [N_OPERATORS];
    logic                           audible [N_OPERATORS];
    logic                           advance;

    fm_reg_bank u_fm_reg_bank (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready),
        .advance   (advance),
        .ch_cfg    (ch_cfg),
        .op_cfg    (op_cfg)
    );

    operator_router u_operator_router (
        .ch_cfg  (ch_cfg),
        .op_cfg  (op_cfg),
        .op_out  (op_out),
        .op_ctrl (op_ctrl),
        .op_mod  (op_mod)
    );

    for (genvar i = 0; i < N_OPERATORS; i++) begin : g_op
        fm_operator u_fm_operator (
            .clk     (clk),
            .reset   (reset),
            .advance (advance),
            .ctrl    (op_ctrl[i]),
            .mod_in  (op_mod[i]),
            .out     (op_out[i])
        );

        assign audible[i] = op_ctrl[i].audible;
    end

    sample_mixer u_sample_mixer (
        .clk           (clk),
        .reset         (reset),
        .sample_clk_en (sample_clk_en),
        .op_out        (op_out),
        .audible       (audible),
        .advance       (advance),
        .sample        (sample),
        .out_valid     (out_valid),
        .out_ready     (out_ready)
    );

endmodule

//--- src/fm_operator.sv
// one operator with phase wrapping at 2^19 and a wave index taken modulo 1024 after modulation
`timescale 1ns/1ps

module fm_operator (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           advance,
    input  synth_types_pkg::op_ctrl_t                      ctrl,
    input  logic [synth_types_pkg::WAVE_INDEX_WIDTH-1:0]   mod_in,
    output logic signed [synth_types_pkg::OP_OUT_WIDTH-1:0] out
);
    import synth_types_pkg::*;

    logic [PHASE_WIDTH-1:0]              phase;
    logic [PHASE_WIDTH-1:0]              phase_next;
    logic [3:0]                          fb_shift;
    logic signed [OP_OUT_WIDTH-1:0]      fb_scaled;
    logic [WAVE_INDEX_WIDTH-1:0]         fb_term;
    logic [WAVE_INDEX_WIDTH-1:0]         wave_idx;
    logic [WAVE_INDEX_WIDTH-2:0]         tri_idx;
    logic signed [OP_OUT_WIDTH-1:0]      wave_val;
    logic signed [OP_OUT_WIDTH-1:0]      out_next;

    always_comb begin
        phase_next = phase + ctrl.phase_inc[PHASE_WIDTH-1:0];   // wraps

        fb_shift = 4'(FB_SHIFT_BASE) - 4'(ctrl.fb);
        fb_scaled = out >>> fb_shift;                          // previous output
        fb_term = (ctrl.fb == '0) ? '0 : fb_scaled[WAVE_INDEX_WIDTH-1:0];

        wave_idx = phase_next[PHASE_WIDTH-1 -: WAVE_INDEX_WIDTH] + mod_in + fb_term;

        // mirror second half for the falling slope
        tri_idx = wave_idx[WAVE_INDEX_WIDTH-1] ? ~wave_idx[WAVE_INDEX_WIDTH-2:0]
                                               : wave_idx[WAVE_INDEX_WIDTH-2:0];

        unique case (ctrl.waveform)
            WAVE_TRIANGLE: begin
                // 16*q - 4096, msb flip does the offset
                wave_val = $signed({~tri_idx[WAVE_INDEX_WIDTH-2],
                                    tri_idx[WAVE_INDEX_WIDTH-3:0], 4'b0000});
            end
            WAVE_SQUARE: begin
                wave_val = wave_idx[WAVE_INDEX_WIDTH-1] ? OP_OUT_WIDTH'(-OP_PEAK)
                                                        : OP_OUT_WIDTH'(OP_PEAK);
            end
            WAVE_SAW: begin
                wave_val = $signed({~wave_idx[WAVE_INDEX_WIDTH-1],
                                    wave_idx[WAVE_INDEX_WIDTH-2:0], 3'b000}); // 8*p - 4096
            end
            WAVE_HALF_SQUARE: begin
                wave_val = wave_idx[WAVE_INDEX_WIDTH-1] ? '0 : OP_OUT_WIDTH'(OP_PEAK);
            end
            default: begin
                wave_val = '0;
            end
        endcase

        out_next = wave_val >>> ctrl.att_shift;
    end

    always_ff @(posedge clk) begin
        if (reset || !ctrl.kon) begin
            phase <= '0;                                       // key-off restarts at zero
            out <= '0;
        end else if (advance) begin
            phase <= phase_next;
            out <= out_next;
        end
    end

endmodule

//--- src/fm_reg_bank.sv
// config registers written one field group at a time, writes are refused only during an advance cycle
`timescale 1ns/1ps

module fm_reg_bank (
    input  logic                          clk,
    input  logic                          reset,
    input  synth_regmap_pkg::reg_write_t  cfg,
    input  logic                          cfg_valid,
    output logic                          cfg_ready,
    input  logic                          advance,
    output synth_types_pkg::ch_cfg_t      ch_cfg [synth_types_pkg::N_CHANNELS],
    output synth_types_pkg::op_cfg_t      op_cfg [synth_types_pkg::N_OPERATORS]
);
    import synth_types_pkg::*;
    import synth_regmap_pkg::*;

    logic                          write_en;
    reg_group_e                    group;
    logic [INDEX_WIDTH-1:0]        index;
    logic [OP_INDEX_WIDTH-1:0]     op_sel;
    logic [CH_INDEX_WIDTH-1:0]     ch_sel;
    logic                          op_hit;
    logic                          ch_hit;

    assign cfg_ready = !advance;                // no change lands mid-sample
    assign write_en = cfg_valid && cfg_ready;

    assign group = reg_group_e'(cfg.addr[ADDR_GROUP_LSB +: GROUP_WIDTH]);
    assign index = cfg.addr[INDEX_WIDTH-1:0];
    assign op_sel = index[OP_INDEX_WIDTH-1:0];
    assign ch_sel = index[CH_INDEX_WIDTH-1:0];
    assign op_hit = index < N_OPERATORS;
    assign ch_hit = index < N_CHANNELS;

    always_ff @(posedge clk) begin
        if (reset) begin
            ch_cfg <= '{default: '0};
            op_cfg <= '{default: '0};
        end else if (write_en) begin
            case (group)
                GRP_OP_MULT_WS: begin
                    if (op_hit) begin
                        op_cfg[op_sel].mult <= cfg.data[MULT_LSB +: MULT_WIDTH];
                        op_cfg[op_sel].waveform <= waveform_e'(cfg.data[WS_LSB +: WS_WIDTH]);
                    end
                end
                GRP_OP_TL: begin
                    if (op_hit) begin
                        op_cfg[op_sel].tl <= cfg.data[TL_LSB +: TL_WIDTH];
                    end
                end
                GRP_CH_FNUM_LO: begin
                    if (ch_hit) begin
                        ch_cfg[ch_sel].fnum[FNUM_LO_WIDTH-1:0] <= cfg.data[FNUM_LO_WIDTH-1:0];
                    end
                end
                GRP_CH_FNUM_HI: begin
                    if (ch_hit) begin
                        ch_cfg[ch_sel].fnum[FNUM_WIDTH-1:FNUM_LO_WIDTH] <=
                            cfg.data[FNUM_HI_LSB +: FNUM_WIDTH - FNUM_LO_WIDTH];
                        ch_cfg[ch_sel].block <= cfg.data[BLOCK_LSB +: BLOCK_WIDTH];
                        ch_cfg[ch_sel].kon <= cfg.data[KON_BIT];
                    end
                end
                GRP_CH_FB_CNT: begin
                    if (ch_hit) begin
                        ch_cfg[ch_sel].fb <= cfg.data[FB_LSB +: FB_WIDTH];
                        ch_cfg[ch_sel].cnt <= cfg.data[CNT_BIT];
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- src/operator_router.sv
// two-op channel wiring, where the carrier sees the modulator's previous output and only in fm mode
`timescale 1ns/1ps

module operator_router (
    input  synth_types_pkg::ch_cfg_t  ch_cfg [synth_types_pkg::N_CHANNELS],
    input  synth_types_pkg::op_cfg_t  op_cfg [synth_types_pkg::N_OPERATORS],
    input  logic signed [synth_types_pkg::OP_OUT_WIDTH-1:0]
                                      op_out [synth_types_pkg::N_OPERATORS],
    output synth_types_pkg::op_ctrl_t op_ctrl [synth_types_pkg::N_OPERATORS],
    output logic [synth_types_pkg::WAVE_INDEX_WIDTH-1:0]
                                      op_mod [synth_types_pkg::N_OPERATORS]
);
    import synth_types_pkg::*;

    function automatic op_ctrl_t build_ctrl(
        input ch_cfg_t ch,
        input op_cfg_t op,
        input logic    carrier
    );
        op_ctrl_t                   ctrl;
        logic [PHASE_INC_WIDTH-1:0] base;

        base = PHASE_INC_WIDTH'(ch.fnum) << ch.block;
        if (op.mult == '0) begin
            ctrl.phase_inc = base >> 1;             // mult 0 means x0.5
        end else begin
            ctrl.phase_inc = base * op.mult;
        end
        ctrl.waveform = op.waveform;
        ctrl.att_shift = op.tl[TL_WIDTH-1:TL_WIDTH-ATT_WIDTH];
        ctrl.kon = ch.kon;
        ctrl.fb = carrier ? '0 : ch.fb;             // feedback on modulator only
        ctrl.audible = carrier || ch.cnt;
        return ctrl;
    endfunction

    for (genvar c = 0; c < N_CHANNELS; c++) begin : g_ch
        // modulator
        assign op_ctrl[2*c] = build_ctrl(ch_cfg[c], op_cfg[2*c], 1'b0);
        assign op_mod[2*c] = '0;

        // carrier
        assign op_ctrl[2*c+1] = build_ctrl(ch_cfg[c], op_cfg[2*c+1], 1'b1);
        assign op_mod[2*c+1] = ch_cfg[c].cnt ? '0 : op_out[2*c][WAVE_INDEX_WIDTH-1:0];
    end

endmodule

//--- src/sample_mixer.sv
// mono mixer with one sample in flight, and a tick that finds the output slot busy is dropped
`timescale 1ns/1ps

module sample_mixer (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            sample_clk_en,
    input  logic signed [synth_types_pkg::OP_OUT_WIDTH-1:0]
                                                            op_out [synth_types_pkg::N_OPERATORS],
    input  logic                                            audible [synth_types_pkg::N_OPERATORS],
    output logic                                            advance,
    output logic signed [synth_types_pkg::SAMPLE_WIDTH-1:0] sample,
    output logic                                            out_valid,
    input  logic                                            out_ready
);
    import synth_types_pkg::*;

    logic                           pending;    // capture due next edge
    logic                           slot_free;
    logic signed [MIX_WIDTH-1:0]    mix_sum;
    logic signed [SAMPLE_WIDTH-1:0] mix_sat;
    logic                           in_range;

    assign slot_free = !pending && (!out_valid || out_ready);
    assign advance = sample_clk_en && slot_free;

    always_comb begin
        mix_sum = '0;
        for (int i = 0; i < N_OPERATORS; i++) begin
            if (audible[i]) begin
                mix_sum = mix_sum + MIX_WIDTH'(op_out[i]);     // sign extended
            end
        end

        in_range = (mix_sum[MIX_WIDTH-1:SAMPLE_WIDTH-1] == '0) ||
                   (mix_sum[MIX_WIDTH-1:SAMPLE_WIDTH-1] == '1);
        if (in_range) begin
            mix_sat = mix_sum[SAMPLE_WIDTH-1:0];
        end else if (mix_sum[MIX_WIDTH-1]) begin
            mix_sat = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};       // -32768
        end else begin
            mix_sat = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};       // +32767
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            pending <= advance;
            if (pending) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sample <= '0;
        end else if (pending) begin
            sample <= mix_sat;
        end
    end

endmodule

//--- src/synth_regmap_pkg.sv
// register map with the group in addr[7:4] and the index in addr[3:0], unknown groups are dropped
package synth_regmap_pkg;

    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 8;
    localparam int INDEX_WIDTH = 4;
    localparam int GROUP_WIDTH = 4;
    localparam int ADDR_GROUP_LSB = INDEX_WIDTH;

    typedef enum logic [GROUP_WIDTH-1:0] {
        GRP_OP_MULT_WS = 4'h2,
        GRP_OP_TL      = 4'h4,
        GRP_CH_FNUM_LO = 4'hA,
        GRP_CH_FNUM_HI = 4'hB,
        GRP_CH_FB_CNT  = 4'hC
    } reg_group_e;

    // GRP_OP_MULT_WS
    localparam int MULT_LSB = 0;
    localparam int WS_LSB = 4;

    // GRP_OP_TL
    localparam int TL_LSB = 0;

    // GRP_CH_FNUM_LO / GRP_CH_FNUM_HI
    localparam int FNUM_LO_WIDTH = 8;
    localparam int FNUM_HI_LSB = 0;
    localparam int BLOCK_LSB = 2;
    localparam int KON_BIT = 5;

    // GRP_CH_FB_CNT
    localparam int FB_LSB = 0;
    localparam int CNT_BIT = 3;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } reg_write_t;

endpackage

//--- src/synth_types_pkg.sv
// synth-wide widths and config types, where operator 2c is the modulator of channel c and 2c+1 its carrier
package synth_types_pkg;

    localparam int N_CHANNELS = 4;
    localparam int N_OPERATORS = 8;
    localparam int OP_INDEX_WIDTH = $clog2(N_OPERATORS);
    localparam int CH_INDEX_WIDTH = $clog2(N_CHANNELS);

    localparam int FNUM_WIDTH = 10;
    localparam int BLOCK_WIDTH = 3;
    localparam int MULT_WIDTH = 4;
    localparam int TL_WIDTH = 6;
    localparam int FB_WIDTH = 3;
    localparam int WS_WIDTH = 2;

    localparam int PHASE_WIDTH = 19;
    localparam int PHASE_INC_WIDTH = PHASE_WIDTH + MULT_WIDTH;
    localparam int WAVE_INDEX_WIDTH = 10;          // top phase bits fed to the waveform
    localparam int ATT_WIDTH = TL_WIDTH - 2;       // tl / 4
    localparam int FB_SHIFT_BASE = 9;

    localparam int OP_OUT_WIDTH = 13;
    localparam int OP_PEAK = 4095;
    localparam int SAMPLE_WIDTH = 16;
    localparam int MIX_WIDTH = OP_OUT_WIDTH + OP_INDEX_WIDTH + 1; // headroom for saturation

    typedef enum logic [WS_WIDTH-1:0] {
        WAVE_TRIANGLE    = 2'd0,
        WAVE_SQUARE      = 2'd1,
        WAVE_SAW         = 2'd2,
        WAVE_HALF_SQUARE = 2'd3
    } waveform_e;

    typedef struct packed {
        logic [MULT_WIDTH-1:0] mult;
        waveform_e             waveform;
        logic [TL_WIDTH-1:0]   tl;
    } op_cfg_t;

    typedef struct packed {
        logic [FNUM_WIDTH-1:0]  fnum;
        logic [BLOCK_WIDTH-1:0] block;
        logic                   kon;
        logic [FB_WIDTH-1:0]    fb;
        logic                   cnt;    // 0 fm, 1 additive
    } ch_cfg_t;

    typedef struct packed {
        logic [PHASE_INC_WIDTH-1:0] phase_inc;
        waveform_e                  waveform;
        logic [ATT_WIDTH-1:0]       att_shift;
        logic                       kon;
        logic [FB_WIDTH-1:0]        fb;
        logic                       audible;
    } op_ctrl_t;

endpackage

//--- verif/fm_channels_tb.sv
// directed tests with a behavioral model, stops at the first mismatch, register writes only when idle
`timescale 1ns/1ps

module fm_channels_tb;
    import synth_types_pkg::*;
    import synth_regmap_pkg::*;

    localparam int TOTAL_SAMPLES = 16 + 32 + 48 + 8 + 64 + 8 + 16;
    localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 20 + 1000;   // margin for reset and writes

    logic                           clk;
    logic                           reset;
    logic                           sample_clk_en;
    reg_write_t                     cfg;
    logic                           cfg_valid;
    logic                           cfg_ready;
    logic signed [SAMPLE_WIDTH-1:0] sample;
    logic                           out_valid;
    logic                           out_ready;

    logic [31:0] rand_state = 32'hb75821f5;
    int          ch_fnum [N_CHANNELS];
    int          ch_block [N_CHANNELS];
    int          ch_fb [N_CHANNELS];
    bit          ch_kon [N_CHANNELS];
    bit          ch_cnt [N_CHANNELS];
    int          op_mult [N_OPERATORS];
    int          op_wave [N_OPERATORS];
    int          op_tl [N_OPERATORS];
    int          op_phase [N_OPERATORS];    // model state
    int          op_out [N_OPERATORS];
    int          captured [$];
    bit          holding;
    int          held_sample;

    tb_clock_gen u_tb_clock_gen (.clk(clk));

    fm_channels u_fm_channels (
        .clk           (clk),
        .reset         (reset),
        .sample_clk_en (sample_clk_en),
        .cfg           (cfg),
        .cfg_valid     (cfg_valid),
        .cfg_ready     (cfg_ready),
        .sample        (sample),
        .out_valid     (out_valid),
        .out_ready     (out_ready)
    );

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string name, input int expected, input int actual);
        if (expected != actual) begin
            report_failure($sformatf("ERROR %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    function automatic int wave_value(input int wave, input int p);
        case (wave)
            WAVE_TRIANGLE: return (p < 512) ? 16 * p - 4096 : 16 * (1023 - p) - 4096;
            WAVE_SQUARE: return (p < 512) ? 4095 : -4095;
            WAVE_SAW: return 8 * p - 4096;
            default: return (p < 512) ? 4095 : 0;
        endcase
    endfunction

    // one accepted sample, all operators step from the previous outputs
    task automatic model_step(input bit no_mod, output int expected);
        int next_phase [N_OPERATORS];
        int next_out [N_OPERATORS];
        int c;
        int inc;
        int fb_term;
        int mod;
        int p;
        expected = 0;
        for (int o = 0; o < N_OPERATORS; o++) begin
            c = o / 2;
            inc = ch_fnum[c] << ch_block[c];
            inc = (op_mult[o] == 0) ? inc >> 1 : inc * op_mult[o];
            next_phase[o] = ch_kon[c] ? (op_phase[o] + inc) & 32'h7ffff : 0;
            fb_term = (o % 2 == 0 && ch_fb[c] != 0) ? (op_out[o] >>> (9 - ch_fb[c])) & 1023 : 0;
            mod = (o % 2 == 1 && !ch_cnt[c] && !no_mod) ? op_out[2 * c] & 1023 : 0;
            p = ((next_phase[o] >> 9) + mod + fb_term) & 1023;
            next_out[o] = ch_kon[c] ? wave_value(op_wave[o], p) >>> (op_tl[o] >> 2) : 0;
            if (o % 2 == 1 || ch_cnt[c]) begin
                expected += next_out[o];
            end
        end
        op_phase = next_phase;
        op_out = next_out;
        if (expected > 32767) begin
            expected = 32767;
        end else if (expected < -32768) begin
            expected = -32768;
        end
    endtask

    task automatic write_reg(input reg_group_e grp, input int idx, input logic [7:0] data);
        @(posedge clk);
        cfg.addr <= {grp, 4'(idx)};
        cfg.data <= data;
        cfg_valid <= 1'b1;
        @(negedge clk);
        while (!cfg_ready) begin
            @(negedge clk);
        end
        @(posedge clk);                 // accepted on this edge
        cfg_valid <= 1'b0;
    endtask

    task automatic set_channel(input int c, input int fnum, input int block, input bit kon,
                               input int fb, input bit cnt);
        write_reg(GRP_CH_FNUM_LO, c, 8'(fnum));
        write_reg(GRP_CH_FNUM_HI, c, {2'b00, kon, 3'(block), 2'(fnum >> 8)});
        write_reg(GRP_CH_FB_CNT, c, {4'b0000, cnt, 3'(fb)});
        ch_fnum[c] = fnum & 1023;
        ch_block[c] = block & 7;
        ch_kon[c] = kon;
        ch_fb[c] = fb & 7;
        ch_cnt[c] = cnt;
        if (!kon) begin
            op_phase[2 * c] = 0;        // key-off holds both operators at zero
            op_phase[2 * c + 1] = 0;
            op_out[2 * c] = 0;
            op_out[2 * c + 1] = 0;
        end
    endtask

    task automatic set_operator(input int o, input int mult, input int wave, input int tl);
        write_reg(GRP_OP_MULT_WS, o, {2'b00, 2'(wave), 4'(mult)});
        write_reg(GRP_OP_TL, o, {2'b00, 6'(tl)});
        op_mult[o] = mult & 15;
        op_wave[o] = wave & 3;
        op_tl[o] = tl & 63;
    endtask

    task automatic randomize_all();
        for (int c = 0; c < N_CHANNELS; c++) begin
            set_channel(c, next_random() >> 22, next_random() >> 29, 1'b1,
                        next_random() >> 29, next_random() >> 31);
        end
        for (int o = 0; o < N_OPERATORS; o++) begin
            set_operator(o, next_random() >> 28, next_random() >> 30, next_random() >> 28);
        end
    endtask

    task automatic observe_output(input string name);
        int expected;
        @(negedge clk);
        if (holding) begin
            if (!out_valid) begin
                report_failure("out_valid dropped before the held sample was taken");
            end
            check_equal({name, " held"}, held_sample, sample);
        end
        holding = out_valid && !out_ready;
        held_sample = sample;
        if (out_valid && out_ready) begin
            model_step(1'b0, expected);
            check_equal(name, expected, sample);
            captured.push_back(sample);
        end
    endtask

    task automatic run_samples(input string name, input int count, input bit random_ready);
        int          target;
        logic [31:0] r;
        target = captured.size() + count;
        while (captured.size() < target) begin
            r = next_random();
            @(posedge clk);
            sample_clk_en <= 1'b1;
            out_ready <= random_ready ? r[31] : 1'b1;
            observe_output(name);
        end
        @(posedge clk);
        sample_clk_en <= 1'b0;
        out_ready <= 1'b1;
        repeat (4) begin
            observe_output(name);       // drain a late sample
        end
    endtask

    task automatic idle_after_reset();
        repeat (20) begin
            @(negedge clk);
            check_equal("idle_after_reset out_valid", 0, out_valid);
            check_equal("idle_after_reset cfg_ready", 1, cfg_ready);
        end
    endtask

    task automatic additive_square_tone();
        int phase;
        int level;
        set_operator(0, 1, WAVE_HALF_SQUARE, 63);   // silent modulator
        set_operator(1, 1, WAVE_SQUARE, 8);
        set_channel(0, 341, 7, 1'b1, 0, 1'b1);
        captured.delete();
        run_samples("additive_square", 16, 1'b0);
        phase = 0;                                  // carrier starts at zero after reset
        foreach (captured[i]) begin
            phase = (phase + (341 << 7)) & 32'h7ffff;
            level = ((phase >> 9) < 512) ? 1023 : -1024;    // +-4095 >>> 2
            check_equal("additive_square level", level, captured[i]);
        end
    endtask

    task automatic fm_random_tone();
        int          plain [$];
        int          saved_phase [N_OPERATORS];
        int          saved_out [N_OPERATORS];
        int          expected;
        int          diffs;
        logic [31:0] r;
        r = next_random();
        set_operator(0, r[3:0], WAVE_SQUARE, 0);
        set_operator(1, r[7:4], WAVE_SAW, 0);
        set_channel(0, r[17:8] | 10'h040, r[20:18], 1'b1, 0, 1'b0);
        saved_phase = op_phase;
        saved_out = op_out;
        repeat (32) begin
            model_step(1'b1, expected);
            plain.push_back(expected);
        end
        op_phase = saved_phase;
        op_out = saved_out;
        captured.delete();
        run_samples("fm_random", 32, 1'b0);
        diffs = 0;
        foreach (plain[i]) begin
            diffs += (plain[i] != captured[i]);
        end
        if (diffs == 0) begin
            report_failure("the FM carrier matched the unmodulated sequence");
        end
    endtask

    task automatic four_channel_mix();
        int full;
        randomize_all();
        captured.delete();
        run_samples("four_channel_mix", 48, 1'b0);
        for (int o = 0; o < N_OPERATORS; o++) begin
            set_operator(o, 1, WAVE_SQUARE, 0);
        end
        for (int c = 0; c < N_CHANNELS; c++) begin
            set_channel(c, 1, 0, 1'b0, 0, 1'b1);
            set_channel(c, 1, 0, 1'b1, 0, 1'b1);
        end
        full = (8 * 4095 > 32767) ? 32767 : 8 * 4095;
        captured.delete();
        run_samples("full_level", 8, 1'b0);
        foreach (captured[i]) begin
            check_equal("full_level sum", full, captured[i]);
        end
    endtask

    task automatic back_pressure_run();
        randomize_all();
        run_samples("back_pressure", 64, 1'b1);
    endtask

    task automatic key_off_restart();
        for (int c = 0; c < N_CHANNELS; c++) begin
            set_channel(c, ch_fnum[c], ch_block[c], 1'b0, ch_fb[c], ch_cnt[c]);
        end
        captured.delete();
        run_samples("key_off", 8, 1'b0);
        foreach (captured[i]) begin
            check_equal("key_off silence", 0, captured[i]);
        end
        for (int c = 0; c < N_CHANNELS; c++) begin
            set_channel(c, ch_fnum[c], ch_block[c], 1'b1, ch_fb[c], ch_cnt[c]);
        end
        run_samples("key_on", 16, 1'b0);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("timeout, the tests did not finish in time");
    end

    initial begin
        reset = 1'b1;
        sample_clk_en = 1'b0;
        cfg = '0;
        cfg_valid = 1'b0;
        out_ready = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        idle_after_reset();
        additive_square_tone();
        fm_random_tone();
        four_channel_mix();
        back_pressure_run();
        key_off_restart();
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
// free-running testbench clock, starts low at time zero and never stops on its own
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule
